// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - include_dirs:
      - .
    files:
      - csr_pkg.sv
      - csr_exec_if.sv
      - csr_host_port.sv
      - csr_decode.sv
      - csr_file.sv
      - csr_unit_top.sv
  - target: test
    files:
      - csr_unit_tb.sv

// ==== csr_decode.sv ====
`timescale 1ns/1ps

module csr_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue,
    input  csr_pkg::inst_t       issue_inst,
    input  csr_pkg::arch_width_t issue_rs1,
    csr_exec_if.decode           exec
);

logic [6:0] opcode;
logic [4:0] rd;
logic [2:0] funct3;
logic [4:0] rs1; // also zimm
logic [11:0] raw_addr;
logic is_system;
logic f3_ok;
logic addr_ok;
logic time_wr;
logic dec_illegal;
csr_pkg::csr_ctrl_t ctrl;
csr_pkg::arch_width_t src;

assign opcode = issue_inst[6:0];
assign rd = issue_inst[11:7];
assign funct3 = issue_inst[14:12];
assign rs1 = issue_inst[19:15];
assign raw_addr = issue_inst[31:20];

assign is_system = (opcode == 7'b1110011);
assign f3_ok = (funct3[1:0] != 2'b00); // 0 and 4 are not Zicsr

always_comb begin
    ctrl.en = is_system;
    ctrl.ui = funct3[2];
    case (funct3[1:0])
        2'b10: ctrl.op = csr_pkg::csr_op_rs;
        2'b11: ctrl.op = csr_pkg::csr_op_rc;
        default: ctrl.op = csr_pkg::csr_op_rw;
    endcase
    if (ctrl.op == csr_pkg::csr_op_rw) begin
        ctrl.re = (rd != 5'd0); // no read side effect for rd x0
        ctrl.we = 1'b1;
    end else begin
        ctrl.re = 1'b1;
        ctrl.we = (rs1 != 5'd0); // set/clear with zero is read only
    end
end

always_comb begin
    case (raw_addr)
        csr_pkg::csr_tohost,
        csr_pkg::csr_mscratch,
        csr_pkg::csr_mcycle,
        csr_pkg::csr_mcycleh,
        csr_pkg::csr_minstret,
        csr_pkg::csr_minstreth,
        csr_pkg::csr_time,
        csr_pkg::csr_timeh: addr_ok = 1'b1;
        default: addr_ok = 1'b0;
    endcase
end

// time is read only
assign time_wr = ctrl.we &&
    ((raw_addr == csr_pkg::csr_time) || (raw_addr == csr_pkg::csr_timeh));
assign dec_illegal = !is_system || !f3_ok || !addr_ok || time_wr;

assign src = ctrl.ui ? csr_pkg::arch_width_t'(rs1) : issue_rs1;

always_ff @(posedge clk) begin
    if (rst) begin
        exec.valid <= 1'b0;
    end else begin
        exec.valid <= issue;
    end
end

always_ff @(posedge clk) begin
    if (issue) begin
        exec.ctrl <= ctrl;
        exec.addr <= csr_pkg::csr_addr_t'(raw_addr);
        exec.src <= src;
        exec.illegal <= dec_illegal;
    end
end

endmodule

// ==== csr_exec_if.sv ====
`timescale 1ns/1ps

// one decoded instruction, decode to execute
interface csr_exec_if;

logic                 valid; // single cycle
csr_pkg::csr_ctrl_t   ctrl;
csr_pkg::csr_addr_t   addr;
csr_pkg::arch_width_t src;   // rs1 or zimm, already selected
logic                 illegal;

modport decode (
    output valid,
    output ctrl,
    output addr,
    output src,
    output illegal
);

modport exec (
    input valid,
    input ctrl,
    input addr,
    input src,
    input illegal
);

endinterface

// ==== csr_file.sv ====
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_file (
    input  logic                 clk,
    input  logic                 rst,
    csr_exec_if.exec             exec,
    output logic                 rsp_valid,
    output csr_pkg::arch_width_t rsp_data,
    output logic                 rsp_illegal,
    output csr_pkg::arch_width_t tohost
);

csr_pkg::arch_width_t mscratch;
csr_pkg::csr_dword_t mcycle;
csr_pkg::csr_dword_t minstret;
csr_pkg::csr_dword_t mtime;
csr_pkg::arch_width_t cur_val;
csr_pkg::arch_width_t rd_val;
csr_pkg::arch_width_t wr_data;
logic retire;
logic rd_en;
logic wr_en;
logic wr_mcycle_l;
logic wr_mcycle_h;
logic wr_minstret_l;
logic wr_minstret_h;
logic tick_us;
logic [`CSR_US_CNT_W-1:0] cnt_us;

// legal instruction retires here
assign retire = exec.valid && exec.ctrl.en && !exec.illegal;
assign rd_en = retire && exec.ctrl.re;
assign wr_en = retire && exec.ctrl.we;

always_comb begin
    case (exec.addr)
        csr_pkg::csr_tohost: cur_val = tohost;
        csr_pkg::csr_mscratch: cur_val = mscratch;
        csr_pkg::csr_mcycle: cur_val = mcycle[`CSR_XLEN-1:0];
        csr_pkg::csr_mcycleh: cur_val = mcycle[2*`CSR_XLEN-1:`CSR_XLEN];
        csr_pkg::csr_minstret: cur_val = minstret[`CSR_XLEN-1:0];
        csr_pkg::csr_minstreth: cur_val = minstret[2*`CSR_XLEN-1:`CSR_XLEN];
        csr_pkg::csr_time: cur_val = mtime[`CSR_XLEN-1:0];
        csr_pkg::csr_timeh: cur_val = mtime[2*`CSR_XLEN-1:`CSR_XLEN];
        default: cur_val = '0;
    endcase
end

assign rd_val = rd_en ? cur_val : '0; // zero for illegal or rd x0

// read-modify-write source
always_comb begin
    case (exec.ctrl.op)
        csr_pkg::csr_op_rs: wr_data = cur_val | exec.src;
        csr_pkg::csr_op_rc: wr_data = cur_val & ~exec.src;
        default: wr_data = exec.src;
    endcase
end

always_ff @(posedge clk) begin
    if (rst) begin
        tohost <= '0;
        mscratch <= '0;
    end else if (wr_en) begin
        case (exec.addr)
            csr_pkg::csr_tohost: tohost <= wr_data;
            csr_pkg::csr_mscratch: mscratch <= wr_data;
            default: ;
        endcase
    end
end

assign wr_mcycle_l = wr_en && (exec.addr == csr_pkg::csr_mcycle);
assign wr_mcycle_h = wr_en && (exec.addr == csr_pkg::csr_mcycleh);
assign wr_minstret_l = wr_en && (exec.addr == csr_pkg::csr_minstret);
assign wr_minstret_h = wr_en && (exec.addr == csr_pkg::csr_minstreth);

// free running, paused for the write cycle
always_ff @(posedge clk) begin
    if (rst) begin
        mcycle <= '0;
    end else if (wr_mcycle_l) begin
        mcycle[`CSR_XLEN-1:0] <= wr_data;
    end else if (wr_mcycle_h) begin
        mcycle[2*`CSR_XLEN-1:`CSR_XLEN] <= wr_data;
    end else begin
        mcycle <= mcycle + csr_pkg::csr_dword_t'(1);
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        minstret <= '0;
    end else if (wr_minstret_l) begin
        minstret[`CSR_XLEN-1:0] <= wr_data;
    end else if (wr_minstret_h) begin
        minstret[2*`CSR_XLEN-1:`CSR_XLEN] <= wr_data;
    end else begin
        minstret <= minstret + csr_pkg::csr_dword_t'(retire);
    end
end

// microsecond divider
always_ff @(posedge clk) begin
    if (rst) begin
        cnt_us <= '0;
        tick_us <= 1'b0;
    end else begin
        tick_us <= (cnt_us == `CSR_US_CNT_W'(`CSR_CLOCKS_PER_US - 1));
        if (cnt_us == `CSR_US_CNT_W'(`CSR_CLOCKS_PER_US - 1)) begin
            cnt_us <= '0;
        end else begin
            cnt_us <= cnt_us + 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        mtime <= '0;
    end else begin
        mtime <= mtime + csr_pkg::csr_dword_t'(tick_us);
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        rsp_valid <= 1'b0;
    end else begin
        rsp_valid <= exec.valid;
    end
end

// illegal travels on from decode unchanged
always_ff @(posedge clk) begin
    if (exec.valid) begin
        rsp_data <= rd_val;
        rsp_illegal <= exec.illegal;
    end
end

endmodule

// ==== csr_host_port.sv ====
`timescale 1ns/1ps

module csr_host_port (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  csr_pkg::inst_t       inst,
    input  csr_pkg::arch_width_t rs1_data,
    input  logic                 rsp_valid,
    input  csr_pkg::arch_width_t rsp_data,
    input  logic                 rsp_illegal,
    output logic                 ack,
    output csr_pkg::arch_width_t rdata,
    output logic                 illegal,
    output logic                 issue,
    output csr_pkg::inst_t       issue_inst,
    output csr_pkg::arch_width_t issue_rs1
);

csr_pkg::port_state_t state;
logic accept;
logic rsp_take;

assign accept = (state == csr_pkg::port_idle) && req;
assign rsp_take = (state == csr_pkg::port_busy) && rsp_valid;

// handshake fsm
always_ff @(posedge clk) begin
    if (rst) begin
        state <= csr_pkg::port_idle;
        issue <= 1'b0;
    end else begin
        issue <= accept; // one pulse per request
        case (state)
            csr_pkg::port_idle: begin
                if (req) begin
                    state <= csr_pkg::port_busy;
                end
            end
            csr_pkg::port_busy: begin
                if (rsp_valid) begin
                    state <= csr_pkg::port_done;
                end
            end
            csr_pkg::port_done: begin
                if (!req) begin
                    state <= csr_pkg::port_idle;
                end
            end
            default: state <= csr_pkg::port_idle;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (accept) begin
        issue_inst <= inst;
        issue_rs1 <= rs1_data;
    end
end

// response held until the next request
always_ff @(posedge clk) begin
    if (rsp_take) begin
        rdata <= rsp_data;
        illegal <= rsp_illegal;
    end
end

assign ack = (state == csr_pkg::port_done);

endmodule

// ==== csr_params.svh ====
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// architectural data width
`define CSR_XLEN 32

// core clock in Hz
`define CSR_CLOCK_FREQ 10_000_000

`define CSR_CLOCKS_PER_US (`CSR_CLOCK_FREQ / 1_000_000)

// width of the cycle counter inside one microsecond
`define CSR_US_CNT_W ($clog2(`CSR_CLOCKS_PER_US))

`endif

// ==== csr_pkg.sv ====
`include "csr_params.svh"

package csr_pkg;

typedef logic [`CSR_XLEN-1:0] arch_width_t;
typedef logic [31:0] inst_t;
typedef logic [2*`CSR_XLEN-1:0] csr_dword_t; // 64-bit counters

// supported CSR addresses
typedef enum logic [11:0] {
    csr_tohost    = 12'h51E,
    csr_mscratch  = 12'h340,
    csr_mcycle    = 12'hB00,
    csr_mcycleh   = 12'hB80,
    csr_minstret  = 12'hB02,
    csr_minstreth = 12'hB82,
    csr_time      = 12'hC01,
    csr_timeh     = 12'hC81
} csr_addr_t;

// follows funct3[1:0] of the Zicsr encoding
typedef enum logic [1:0] {
    csr_op_rw = 2'b01,
    csr_op_rs = 2'b10,
    csr_op_rc = 2'b11
} csr_op_t;

typedef struct packed {
    logic    en; // SYSTEM instruction
    logic    re;
    logic    we;
    logic    ui; // zero-extended immediate as source
    csr_op_t op;
} csr_ctrl_t;

// host side handshake
typedef enum logic [1:0] {
    port_idle = 2'd0,
    port_busy = 2'd1,
    port_done = 2'd2
} port_state_t;

endpackage

// ==== csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb;

localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
localparam logic [2:0] F3_RW = 3'd1;
localparam logic [2:0] F3_RS = 3'd2;
localparam logic [2:0] F3_RC = 3'd3;
localparam logic [2:0] F3_RWI = 3'd5;
localparam logic [2:0] F3_RSI = 3'd6;
localparam logic [2:0] F3_RCI = 3'd7;
localparam logic [11:0] A_TOHOST = 12'h51E;
localparam logic [11:0] A_MSCRATCH = 12'h340;
localparam logic [11:0] A_MCYCLE = 12'hB00;
localparam logic [11:0] A_MINSTRET = 12'hB02;
localparam logic [11:0] A_MINSTRETH = 12'hB82;
localparam logic [11:0] A_TIME = 12'hC01;
localparam logic [11:0] A_UNKNOWN = 12'h7C0;
localparam int MAX_ROWS = 32;
localparam int ACK_TIMEOUT = 50; // cycles

typedef enum int {K_EXACT, K_ILLEGAL, K_RANGE, K_TIME, K_SAMPLE, K_PORT} check_kind_t;

logic clk;
logic rst;
logic req;
logic [31:0] inst;
logic [31:0] rs1_data;
logic ack;
logic [31:0] rdata;
logic illegal;
logic [31:0] tohost;

integer seed;
int cycle_cnt;
int n_rows;
int n_pass;
int n_fail;
logic aborted;

// stimulus and expected values, one entry per test
string t_name [MAX_ROWS];
logic [2:0] t_f3 [MAX_ROWS];
logic [4:0] t_rd [MAX_ROWS];
logic [4:0] t_rs1 [MAX_ROWS]; // rs1 field or zimm
logic [11:0] t_addr [MAX_ROWS];
logic [31:0] t_data [MAX_ROWS];
check_kind_t t_kind [MAX_ROWS];
logic [31:0] t_exp [MAX_ROWS];
int t_ref [MAX_ROWS]; // earlier row for delta checks
int t_start [MAX_ROWS];
logic [31:0] t_got [MAX_ROWS];

csr_unit_top i_dut (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .inst     (inst),
    .rs1_data (rs1_data),
    .ack      (ack),
    .rdata    (rdata),
    .illegal  (illegal),
    .tohost   (tohost)
);

always #50 clk = ~clk;

always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
end

task automatic add_row(input string name, input logic [2:0] f3, input logic [4:0] rd,
    input logic [4:0] rs1f, input logic [11:0] addr, input logic [31:0] data,
    input check_kind_t kind, input logic [31:0] exp, input int ref_row);
    t_name[n_rows] = name;
    t_f3[n_rows] = f3;
    t_rd[n_rows] = rd;
    t_rs1[n_rows] = rs1f;
    t_addr[n_rows] = addr;
    t_data[n_rows] = data;
    t_kind[n_rows] = kind;
    t_exp[n_rows] = exp;
    t_ref[n_rows] = ref_row;
    n_rows++;
endtask

task automatic build_table;
    logic [31:0] scratch;
    logic [31:0] r;
    logic [31:0] w;
    logic [4:0] z;
    int idx;
    scratch = '0;
    r = $random(seed);
    add_row("csrrw_mscratch", F3_RW, 5'd1, 5'd2, A_MSCRATCH, r, K_EXACT, scratch, 0);
    scratch = r;
    r = $random(seed);
    add_row("csrrs_mscratch", F3_RS, 5'd1, 5'd2, A_MSCRATCH, r, K_EXACT, scratch, 0);
    scratch = scratch | r;
    r = $random(seed);
    add_row("csrrc_mscratch", F3_RC, 5'd1, 5'd2, A_MSCRATCH, r, K_EXACT, scratch, 0);
    scratch = scratch & ~r;
    r = $random(seed);
    z = r[4:0];
    add_row("csrrwi_mscratch", F3_RWI, 5'd1, z, A_MSCRATCH, r, K_EXACT, scratch, 0);
    scratch = {27'd0, z};
    r = $random(seed);
    z = r[4:0] | 5'd1;
    add_row("csrrsi_mscratch", F3_RSI, 5'd1, z, A_MSCRATCH, r, K_EXACT, scratch, 0);
    scratch = scratch | {27'd0, z};
    r = $random(seed);
    z = r[4:0] | 5'd1;
    add_row("csrrci_mscratch", F3_RCI, 5'd1, z, A_MSCRATCH, r, K_EXACT, scratch, 0);
    scratch = scratch & ~{27'd0, z};
    add_row("readback_mscratch", F3_RS, 5'd1, 5'd0, A_MSCRATCH, '0, K_EXACT, scratch, 0);

    r = $random(seed);
    add_row("write_tohost", F3_RW, 5'd1, 5'd2, A_TOHOST, r, K_PORT, r, 0);
    add_row("readback_tohost", F3_RS, 5'd1, 5'd0, A_TOHOST, '0, K_EXACT, r, 0);

    // minstret set to w, then three legal and three illegal instructions
    w = $random(seed);
    w[31] = 1'b0; // no carry into minstreth
    add_row("write_minstret", F3_RW, 5'd0, 5'd2, A_MINSTRET, w, K_EXACT, '0, 0);
    add_row("write_minstreth", F3_RW, 5'd0, 5'd2, A_MINSTRETH, '0, K_EXACT, '0, 0);
    add_row("spacer_read", F3_RS, 5'd1, 5'd0, A_MSCRATCH, '0, K_EXACT, scratch, 0);
    add_row("unknown_addr", F3_RS, 5'd1, 5'd0, A_UNKNOWN, '0, K_ILLEGAL, '0, 0);
    add_row("funct3_zero", 3'd0, 5'd1, 5'd2, A_MSCRATCH, '0, K_ILLEGAL, '0, 0);
    add_row("funct3_four", 3'd4, 5'd1, 5'd2, A_MSCRATCH, '0, K_ILLEGAL, '0, 0);
    r = $random(seed);
    add_row("csrrw_rd_x0", F3_RW, 5'd0, 5'd2, A_MSCRATCH, r, K_EXACT, '0, 0);
    scratch = r;
    add_row("readback_rd_x0", F3_RS, 5'd1, 5'd0, A_MSCRATCH, '0, K_EXACT, scratch, 0);
    add_row("read_minstret", F3_RS, 5'd1, 5'd0, A_MINSTRET, '0, K_EXACT, w + 32'd3, 0);
    add_row("read_minstreth", F3_RS, 5'd1, 5'd0, A_MINSTRETH, '0, K_EXACT, '0, 0);

    w = $random(seed);
    idx = n_rows;
    add_row("write_mcycle", F3_RW, 5'd0, 5'd2, A_MCYCLE, w, K_EXACT, '0, 0);
    add_row("spacer_read", F3_RS, 5'd1, 5'd0, A_MSCRATCH, '0, K_EXACT, scratch, 0);
    add_row("read_mcycle", F3_RS, 5'd1, 5'd0, A_MCYCLE, '0, K_RANGE, w, idx);

    idx = n_rows;
    add_row("time_first", F3_RS, 5'd1, 5'd0, A_TIME, '0, K_SAMPLE, '0, 0);
    add_row("spacer_read", F3_RS, 5'd1, 5'd0, A_MSCRATCH, '0, K_EXACT, scratch, 0);
    add_row("time_second", F3_RS, 5'd1, 5'd0, A_TIME, '0, K_TIME, '0, idx);
    add_row("write_time", F3_RW, 5'd5, 5'd3, A_TIME, $random(seed), K_ILLEGAL, '0, 0);
    add_row("time_third", F3_RS, 5'd1, 5'd0, A_TIME, '0, K_TIME, '0, idx + 2);
endtask

task automatic check_row(input int i, input logic got_ill, input logic [31:0] got_port);
    logic [31:0] diff;
    logic [31:0] lo;
    logic [31:0] hi;
    logic ok;
    int n;
    n = t_start[i] - t_start[t_ref[i]]; // clocks between request edges
    diff = t_got[i];
    lo = t_exp[i];
    hi = t_exp[i];
    case (t_kind[i])
        K_RANGE: begin
            diff = t_got[i] - t_exp[i];
            lo = 32'd1;
            hi = n + 4;
        end
        K_TIME: begin
            diff = t_got[i] - t_got[t_ref[i]];
            lo = n / 10;
            hi = n / 10 + 1;
        end
        K_PORT: diff = got_port;
        K_SAMPLE: begin
            lo = t_got[i];
            hi = t_got[i];
        end
        default: ;
    endcase
    ok = (diff >= lo) && (diff <= hi);
    if (got_ill !== (t_kind[i] == K_ILLEGAL)) begin
        $display("FAIL %s illegal expected %0b actual %0b", t_name[i],
            t_kind[i] == K_ILLEGAL, got_ill);
        n_fail++;
    end else if (ok !== 1'b1 && lo != hi) begin
        $display("FAIL %s expected delta %0d..%0d actual %0d", t_name[i], lo, hi, diff);
        n_fail++;
    end else if (ok !== 1'b1) begin
        $display("FAIL %s expected %h actual %h", t_name[i], lo, diff);
        n_fail++;
    end else begin
        $display("PASS %s", t_name[i]);
        n_pass++;
    end
endtask

// full four-phase handshake for one row
task automatic run_row(input int i);
    int waited;
    @(posedge clk);
    req <= 1'b1;
    inst <= {t_addr[i], t_rs1[i], t_f3[i], t_rd[i], OPC_SYSTEM};
    rs1_data <= t_data[i];
    t_start[i] = cycle_cnt;
    waited = 0;
    @(negedge clk);
    while (ack !== 1'b1 && waited < ACK_TIMEOUT) begin
        @(negedge clk);
        waited++;
    end
    if (ack !== 1'b1) begin
        $display("%s got no ack within %0d cycles", t_name[i], ACK_TIMEOUT);
        aborted = 1'b1;
    end else begin
        t_got[i] = rdata;
        check_row(i, illegal, tohost);
        @(posedge clk);
        req <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (ack !== 1'b0 && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (ack !== 1'b0) begin
            $display("%s left ack high after req was dropped", t_name[i]);
            aborted = 1'b1;
        end
    end
endtask

initial begin
    seed = 32'h9926d3d7;
    clk = 1'b0;
    rst = 1'b1;
    req = 1'b0;
    inst = '0;
    rs1_data = '0;
    cycle_cnt = 0;
    n_rows = 0;
    n_pass = 0;
    n_fail = 0;
    aborted = 1'b0;
    build_table();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < n_rows && !aborted; i++) begin
        run_row(i);
    end
    $display("tests %0d passed %0d failed %0d", n_rows, n_pass, n_fail);
    if (n_fail == 0 && !aborted) begin
        $display("Finished with no errors");
    end else begin
        $display("Finished with errors");
    end
    $finish;
end

endmodule

// ==== csr_unit_top.sv ====
`timescale 1ns/1ps

module csr_unit_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  csr_pkg::inst_t       inst,
    input  csr_pkg::arch_width_t rs1_data,
    output logic                 ack,
    output csr_pkg::arch_width_t rdata,
    output logic                 illegal,
    output csr_pkg::arch_width_t tohost
);

logic issue;
csr_pkg::inst_t issue_inst;
csr_pkg::arch_width_t issue_rs1;
logic rsp_valid;
csr_pkg::arch_width_t rsp_data;
logic rsp_illegal;

csr_exec_if exec_bus ();

csr_host_port i_port (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .inst        (inst),
    .rs1_data    (rs1_data),
    .rsp_valid   (rsp_valid),
    .rsp_data    (rsp_data),
    .rsp_illegal (rsp_illegal),
    .ack         (ack),
    .rdata       (rdata),
    .illegal     (illegal),
    .issue       (issue),
    .issue_inst  (issue_inst),
    .issue_rs1   (issue_rs1)
);

csr_decode i_decode (
    .clk        (clk),
    .rst        (rst),
    .issue      (issue),
    .issue_inst (issue_inst),
    .issue_rs1  (issue_rs1),
    .exec       (exec_bus.decode)
);

csr_file i_file (
    .clk         (clk),
    .rst         (rst),
    .exec        (exec_bus.exec),
    .rsp_valid   (rsp_valid),
    .rsp_data    (rsp_data),
    .rsp_illegal (rsp_illegal),
    .tohost      (tohost)
);

endmodule

// ==== sources.f ====
+incdir+.
csr_pkg.sv
csr_exec_if.sv
csr_host_port.sv
csr_decode.sv
csr_file.sv
csr_unit_top.sv
csr_unit_tb.sv
